// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  core_pkg::alu_op_t op,
   input  logic [31:0]       a,
   input  logic [31:0]       b,
   output logic [31:0]       y,
   output logic              zero
);
   import core_pkg::*;

   always_comb begin
      case (op)
         ALU_ADD:    y = a + b;
         ALU_SUB:    y = a - b;
         ALU_AND:    y = a & b;
         ALU_OR:     y = a | b;
         ALU_XOR:    y = a ^ b;
         ALU_SHL:    y = a << b[4:0];
         ALU_SHR:    y = a >> b[4:0];
         ALU_PASS_B: y = b;
         default:    y = b;
      endcase
   end

   // loop condition for the sequencer.
   assign zero = (y == 32'd0);

endmodule

`default_nettype wire

// File: source/axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave (
   input  logic               clk,
   input  logic               rst,
   input  logic               awvalid,
   output logic               awready,
   input  bus_pkg::axil_aw_t  aw,
   input  logic               wvalid,
   output logic               wready,
   input  bus_pkg::axil_w_t   w,
   output logic               bvalid,
   input  logic               bready,
   input  logic               arvalid,
   output logic               arready,
   input  bus_pkg::axil_ar_t  ar,
   output logic               rvalid,
   input  logic               rready,
   output bus_pkg::axil_r_t   r,
   output logic               issue_valid,
   output core_pkg::instr_t   issue_instr,
   input  logic               issue_ready,
   input  logic               busy,
   input  logic               illegal,
   output core_pkg::reg_idx_t dbg_addr,
   input  logic [31:0]        dbg_data
);
   import bus_pkg::*;

   logic                   wr_go;
   logic                   wr_hs;
   logic                   ar_go;
   logic                   illegal_q;
   logic [AXIL_DATA_W-1:0] status;
   logic [AXIL_DATA_W-1:0] rdata;

   // instruction writes wait for the core, other writes go straight through.
   assign wr_go = awvalid && wvalid && !awready && !bvalid
                  && (issue_ready || aw.addr != ADDR_INSTR);
   assign wr_hs = awready && awvalid && wvalid;

   always_ff @(posedge clk) begin
      if (rst) begin
         awready     <= 1'b0;
         wready      <= 1'b0;
         bvalid      <= 1'b0;
         issue_valid <= 1'b0;
      end else begin
         awready     <= wr_go;
         wready      <= wr_go;
         issue_valid <= wr_hs && (aw.addr == ADDR_INSTR);
         if (wr_hs) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_hs) begin
         issue_instr <= w.data;
      end
   end

   assign arready  = !rvalid;
   assign ar_go    = arvalid && arready;
   assign dbg_addr = ar.addr[5:2];

   always_comb begin
      status                     = '0;
      status[STATUS_BUSY_BIT]    = busy;
      status[STATUS_ILLEGAL_BIT] = illegal_q;
   end

   always_comb begin
      if (ar.addr == ADDR_STATUS) begin
         rdata = status;
      end else if ((ar.addr & REG_WINDOW_MASK) == ADDR_REG_BASE) begin
         rdata = dbg_data;
      end else begin
         rdata = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rvalid    <= 1'b0;
         illegal_q <= 1'b0;
      end else begin
         if (ar_go) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         // sticky until status is read.
         if (illegal) begin
            illegal_q <= 1'b1;
         end else if (ar_go && ar.addr == ADDR_STATUS) begin
            illegal_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_go) begin
         r.data <= rdata;
         r.resp <= RESP_OKAY;
      end
   end

endmodule

`default_nettype wire

// File: source/bus_pkg.sv
`default_nettype none

package bus_pkg;

   localparam int AXIL_ADDR_W = 8;
   localparam int AXIL_DATA_W = 32;

   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
   } axil_w_t;

   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0] data;
      logic [1:0]             resp;
   } axil_r_t;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // register n sits at ADDR_REG_BASE + 4n.
   localparam logic [AXIL_ADDR_W-1:0] ADDR_INSTR      = 8'h00;
   localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS     = 8'h04;
   localparam logic [AXIL_ADDR_W-1:0] ADDR_REG_BASE   = 8'h40;
   localparam logic [AXIL_ADDR_W-1:0] REG_WINDOW_MASK = 8'hc0;

   localparam int STATUS_BUSY_BIT    = 0;
   localparam int STATUS_ILLEGAL_BIT = 1;

endpackage

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

   typedef logic [3:0] reg_idx_t;

   // opcodes 10 to 15 are illegal and run as no-ops.
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SHL  = 4'd5,
      OP_SHR  = 4'd6,
      OP_LDI  = 4'd7,
      OP_MUL  = 4'd8,
      OP_POPC = 4'd9
   } opcode_t;

   typedef struct packed {
      opcode_t     opcode;
      reg_idx_t    rd;
      reg_idx_t    rs1;
      reg_idx_t    rs2;
      logic [15:0] imm;
   } instr_t;

   typedef struct packed {
      logic        en;
      reg_idx_t    addr;
      logic [31:0] data;
   } reg_wr_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASS_B
   } alu_op_t;

   // loop jumps to target while the step result is nonzero.
   typedef enum logic [1:0] {BR_NEXT, BR_LOOP, BR_DONE} br_t;

   typedef struct packed {
      alu_op_t    op;
      reg_idx_t   dst;
      reg_idx_t   src_a;
      reg_idx_t   src_b;
      logic       use_imm;
      logic [7:0] imm;
      br_t        br;
      logic [4:0] target;
   } uinstr_t;

   localparam int UROM_DEPTH = 32;
   localparam logic [4:0] MUL_ENTRY  = 5'd0;
   localparam logic [4:0] POPC_ENTRY = 5'd9;

   // ghost slots used by the micro programs.
   localparam reg_idx_t GHOST_ZERO = 4'd11;
   localparam reg_idx_t GHOST_TMP  = 4'd12;
   localparam reg_idx_t GHOST_ACC  = 4'd13;
   localparam reg_idx_t GHOST_A    = 4'd14;
   localparam reg_idx_t GHOST_B    = 4'd15;

endpackage

`default_nettype wire

// File: source/exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               issue_valid,
   input  core_pkg::instr_t   issue_instr,
   output logic               issue_ready,
   output logic               busy,
   output logic               illegal,
   output core_pkg::reg_idx_t rd_rs1,
   output core_pkg::reg_idx_t rd_rs2,
   input  logic [31:0]        rs1_data,
   input  logic [31:0]        rs2_data,
   output core_pkg::reg_wr_t  wr,
   output logic               snapshot,
   output core_pkg::reg_idx_t snap_rs1,
   output core_pkg::reg_idx_t snap_rs2,
   output logic               ghost_mode,
   output core_pkg::alu_op_t  alu_op,
   output logic [31:0]        alu_a,
   output logic [31:0]        alu_b,
   input  logic [31:0]        alu_y,
   input  logic               alu_zero,
   output logic               useq_start,
   output logic [4:0]         useq_entry,
   input  core_pkg::uinstr_t  uinstr,
   input  logic               useq_done
);
   import core_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_RUN, S_COMMIT} state_t;

   state_t      state_q;
   reg_idx_t    rd_q;
   logic [31:0] acc_q;
   logic        issue_go;
   logic        is_regular;
   logic        is_ucode;
   alu_op_t     dec_op;

   always_comb begin
      is_regular = 1'b1;
      is_ucode   = 1'b0;
      dec_op     = ALU_ADD;
      case (issue_instr.opcode)
         OP_ADD:  dec_op = ALU_ADD;
         OP_SUB:  dec_op = ALU_SUB;
         OP_AND:  dec_op = ALU_AND;
         OP_OR:   dec_op = ALU_OR;
         OP_XOR:  dec_op = ALU_XOR;
         OP_SHL:  dec_op = ALU_SHL;
         OP_SHR:  dec_op = ALU_SHR;
         OP_LDI:  dec_op = ALU_PASS_B;
         OP_MUL, OP_POPC: begin
            is_regular = 1'b0;
            is_ucode   = 1'b1;
         end
         default: is_regular = 1'b0;
      endcase
   end

   assign issue_go    = issue_valid && (state_q == S_IDLE);
   assign busy        = (state_q != S_IDLE);
   assign issue_ready = !busy;
   assign ghost_mode  = (state_q == S_RUN);
   assign illegal     = issue_go && !is_regular && !is_ucode;
   assign snapshot    = issue_go && is_ucode;
   assign snap_rs1    = issue_instr.rs1;
   assign snap_rs2    = issue_instr.rs2;
   assign useq_start  = snapshot;
   assign useq_entry  = (issue_instr.opcode == OP_MUL) ? MUL_ENTRY : POPC_ENTRY;

   // operand and writeback routing per state.
   always_comb begin
      rd_rs1  = issue_instr.rs1;
      rd_rs2  = issue_instr.rs2;
      alu_op  = dec_op;
      alu_a   = rs1_data;
      alu_b   = (issue_instr.opcode == OP_LDI) ? {16'd0, issue_instr.imm} : rs2_data;
      wr.en   = issue_go && is_regular;
      wr.addr = issue_instr.rd;
      wr.data = alu_y;
      if (state_q == S_RUN) begin
         rd_rs1  = uinstr.src_a;
         rd_rs2  = uinstr.src_b;
         alu_op  = uinstr.op;
         alu_b   = uinstr.use_imm ? {24'd0, uinstr.imm} : rs2_data;
         wr.en   = 1'b1;
         wr.addr = uinstr.dst;
      end else if (state_q == S_COMMIT) begin
         wr.en   = 1'b1;
         wr.addr = rd_q;
         wr.data = acc_q;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE:   if (snapshot) state_q <= S_RUN;
            S_RUN:    if (useq_done) state_q <= S_COMMIT;
            default:  state_q <= S_IDLE;
         endcase
      end
   end

   // done step passes the accumulator through the alu.
   always_ff @(posedge clk) begin
      if (snapshot) begin
         rd_q  <= issue_instr.rd;
         acc_q <= 32'd0;
      end else if (ghost_mode && useq_done && !alu_zero) begin
         acc_q <= alu_y;
      end
   end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic               clk,
   input  logic               rst,
   input  core_pkg::reg_wr_t  wr,
   input  logic               snapshot,
   input  core_pkg::reg_idx_t snap_rs1,
   input  core_pkg::reg_idx_t snap_rs2,
   input  logic               ghost_mode,
   input  core_pkg::reg_idx_t rs1,
   input  core_pkg::reg_idx_t rs2,
   output logic [31:0]        rs1_data,
   output logic [31:0]        rs2_data,
   input  core_pkg::reg_idx_t dbg_addr,
   output logic [31:0]        dbg_data
);
   import core_pkg::*;

   logic [31:0] arch_q  [16];
   logic [31:0] ghost_q [16];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 16; i++) begin
            arch_q[i]  <= 32'd0;
            ghost_q[i] <= 32'd0;
         end
      end else begin
         // full copy, then operand slots.
         if (snapshot) begin
            for (int i = 0; i < 16; i++) begin
               ghost_q[i] <= arch_q[i];
            end
            ghost_q[GHOST_A] <= arch_q[snap_rs1];
            ghost_q[GHOST_B] <= arch_q[snap_rs2];
         end
         if (wr.en) begin
            if (ghost_mode) begin
               ghost_q[wr.addr] <= wr.data;
            end else begin
               arch_q[wr.addr] <= wr.data;
            end
         end
      end
   end

   assign rs1_data = ghost_mode ? ghost_q[rs1] : arch_q[rs1];
   assign rs2_data = ghost_mode ? ghost_q[rs2] : arch_q[rs2];

   // host view is always architectural.
   assign dbg_data = arch_q[dbg_addr];

endmodule

`default_nettype wire

// File: source/ucode_seq.sv
`timescale 1ns/1ps
`default_nettype none

module ucode_seq (
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  logic [4:0]        entry,
   input  logic              result_zero,
   output core_pkg::uinstr_t uinstr,
   output logic              active,
   output logic              done
);
   import core_pkg::*;

   localparam int UPC_W = $clog2(UROM_DEPTH);

   logic [UPC_W-1:0] pc_q;
   logic             active_q;

   function automatic uinstr_t uop(
      input alu_op_t    op,
      input reg_idx_t   dst,
      input reg_idx_t   src_a,
      input reg_idx_t   src_b,
      input logic       use_imm,
      input logic [7:0] imm,
      input br_t        br,
      input logic [4:0] target
   );
      return '{op, dst, src_a, src_b, use_imm, imm, br, target};
   endfunction

   function automatic uinstr_t urom(input logic [UPC_W-1:0] addr);
      uinstr_t w;
      case (addr)
         // multiply by shift and add into acc.
         5'd0:  w = uop(ALU_PASS_B, GHOST_ZERO, GHOST_ZERO, GHOST_ZERO, 1'b1, 8'd0, BR_NEXT, 5'd0);
         5'd1:  w = uop(ALU_PASS_B, GHOST_ACC, GHOST_ACC, GHOST_ACC, 1'b1, 8'd0, BR_NEXT, 5'd0);
         5'd2:  w = uop(ALU_AND, GHOST_TMP, GHOST_B, GHOST_B, 1'b1, 8'd1, BR_NEXT, 5'd0);
         // all ones when the low bit of b is set.
         5'd3:  w = uop(ALU_SUB, GHOST_TMP, GHOST_ZERO, GHOST_TMP, 1'b0, 8'd0, BR_NEXT, 5'd0);
         5'd4:  w = uop(ALU_AND, GHOST_TMP, GHOST_TMP, GHOST_A, 1'b0, 8'd0, BR_NEXT, 5'd0);
         5'd5:  w = uop(ALU_ADD, GHOST_ACC, GHOST_ACC, GHOST_TMP, 1'b0, 8'd0, BR_NEXT, 5'd0);
         5'd6:  w = uop(ALU_SHL, GHOST_A, GHOST_A, GHOST_A, 1'b1, 8'd1, BR_NEXT, 5'd0);
         5'd7:  w = uop(ALU_SHR, GHOST_B, GHOST_B, GHOST_B, 1'b1, 8'd1, BR_LOOP, 5'd2);
         5'd8:  w = uop(ALU_PASS_B, GHOST_ACC, GHOST_ACC, GHOST_ACC, 1'b0, 8'd0, BR_DONE, 5'd0);
         // popcount of b.
         5'd9:  w = uop(ALU_PASS_B, GHOST_ACC, GHOST_ACC, GHOST_ACC, 1'b1, 8'd0, BR_NEXT, 5'd0);
         5'd10: w = uop(ALU_AND, GHOST_TMP, GHOST_B, GHOST_B, 1'b1, 8'd1, BR_NEXT, 5'd0);
         5'd11: w = uop(ALU_ADD, GHOST_ACC, GHOST_ACC, GHOST_TMP, 1'b0, 8'd0, BR_NEXT, 5'd0);
         5'd12: w = uop(ALU_SHR, GHOST_B, GHOST_B, GHOST_B, 1'b1, 8'd1, BR_LOOP, 5'd10);
         5'd13: w = uop(ALU_PASS_B, GHOST_ACC, GHOST_ACC, GHOST_ACC, 1'b0, 8'd0, BR_DONE, 5'd0);
         default: w = uop(ALU_PASS_B, GHOST_ACC, GHOST_ACC, GHOST_ACC, 1'b0, 8'd0, BR_DONE, 5'd0);
      endcase
      return w;
   endfunction

   assign uinstr = urom(pc_q);
   assign active = active_q;
   assign done   = active_q && (uinstr.br == BR_DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         pc_q     <= '0;
         active_q <= 1'b0;
      end else if (start) begin
         pc_q     <= entry;
         active_q <= 1'b1;
      end else if (active_q) begin
         if (done) begin
            active_q <= 1'b0;
         end else if (uinstr.br == BR_LOOP && !result_zero) begin
            pc_q <= uinstr.target;
         end else begin
            pc_q <= pc_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/ucore_top.sv
`timescale 1ns/1ps
`default_nettype none

module ucore_top (
   input  logic              clk,
   input  logic              rst,
   input  logic              awvalid,
   output logic              awready,
   input  bus_pkg::axil_aw_t aw,
   input  logic              wvalid,
   output logic              wready,
   input  bus_pkg::axil_w_t  w,
   output logic              bvalid,
   input  logic              bready,
   input  logic              arvalid,
   output logic              arready,
   input  bus_pkg::axil_ar_t ar,
   output logic              rvalid,
   input  logic              rready,
   output bus_pkg::axil_r_t  r
);
   import core_pkg::*;

   logic        issue_valid;
   logic        issue_ready;
   logic        busy;
   logic        illegal;
   instr_t      issue_instr;
   reg_idx_t    rd_rs1;
   reg_idx_t    rd_rs2;
   reg_idx_t    snap_rs1;
   reg_idx_t    snap_rs2;
   reg_idx_t    dbg_addr;
   logic [31:0] rs1_data;
   logic [31:0] rs2_data;
   logic [31:0] dbg_data;
   reg_wr_t     wr;
   logic        snapshot;
   logic        ghost_mode;
   alu_op_t     alu_op;
   logic [31:0] alu_a;
   logic [31:0] alu_b;
   logic [31:0] alu_y;
   logic        alu_zero;
   logic        useq_start;
   logic [4:0]  useq_entry;
   logic        useq_done;
   uinstr_t     uinstr;

   axil_slave u_axil (
      .clk, .rst,
      .awvalid, .awready, .aw,
      .wvalid, .wready, .w,
      .bvalid, .bready,
      .arvalid, .arready, .ar,
      .rvalid, .rready, .r,
      .issue_valid, .issue_instr, .issue_ready,
      .busy, .illegal,
      .dbg_addr, .dbg_data
   );

   exec_ctrl u_ctrl (
      .clk, .rst,
      .issue_valid, .issue_instr, .issue_ready,
      .busy, .illegal,
      .rd_rs1, .rd_rs2, .rs1_data, .rs2_data,
      .wr, .snapshot, .snap_rs1, .snap_rs2, .ghost_mode,
      .alu_op, .alu_a, .alu_b, .alu_y, .alu_zero,
      .useq_start, .useq_entry, .uinstr, .useq_done
   );

   ucode_seq u_useq (
      .clk, .rst,
      .start       (useq_start),
      .entry       (useq_entry),
      .result_zero (alu_zero),
      .uinstr,
      .active      (),
      .done        (useq_done)
   );

   alu u_alu (
      .op   (alu_op),
      .a    (alu_a),
      .b    (alu_b),
      .y    (alu_y),
      .zero (alu_zero)
   );

   reg_file u_rf (
      .clk, .rst,
      .wr, .snapshot, .snap_rs1, .snap_rs2, .ghost_mode,
      .rs1      (rd_rs1),
      .rs2      (rd_rs2),
      .rs1_data, .rs2_data,
      .dbg_addr, .dbg_data
   );

endmodule

`default_nettype wire

// File: tests/ucore_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ucore_properties (
   input logic             clk,
   input logic             rst,
   input logic             bvalid,
   input logic             bready,
   input logic             rvalid,
   input logic             rready,
   input bus_pkg::axil_r_t r,
   input logic             busy,
   input logic             useq_active,
   input logic [31:0]      arch [16]
);

   // write response held until accepted.
   assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
      else $error("bvalid dropped before bready");

   assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(r))
      else $error("rvalid or read data changed before rready");

   // longest run is a 32 pass multiply loop.
   assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> ##[1:200] !busy)
      else $error("busy stayed high for more than 200 cycles");

   // micro steps leave the architectural file alone.
   for (genvar i = 0; i < 16; i++) begin : g_arch_hold
      assert property (@(posedge clk) disable iff (rst) useq_active |=> $stable(arch[i]))
         else $error("architectural register %0d written during a micro sequence", i);
   end

endmodule

bind ucore_top ucore_properties u_props (
   .clk         (clk),
   .rst         (rst),
   .bvalid      (bvalid),
   .bready      (bready),
   .rvalid      (rvalid),
   .rready      (rready),
   .r           (r),
   .busy        (busy),
   .useq_active (u_useq.active),
   .arch        (u_rf.arch_q)
);

`default_nettype wire

// File: tests/ucore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ucore_tb;
   import core_pkg::*;
   import bus_pkg::*;

   localparam int          CLK_HALF        = 20;
   localparam int          N_TESTS         = 6;
   localparam int          WATCHDOG_CYCLES = N_TESTS * 40 * 80;
   localparam logic [31:0] SEED            = 32'hd07d_a9fe;

   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] got;
      logic [31:0] exp;
   } check_t;

   logic        clk;
   logic        rst;
   logic        awvalid;
   logic        awready;
   axil_aw_t    aw;
   logic        wvalid;
   logic        wready;
   axil_w_t     w;
   logic        bvalid;
   logic        bready;
   logic        arvalid;
   logic        arready;
   axil_ar_t    ar;
   logic        rvalid;
   logic        rready;
   axil_r_t     r;
   logic [31:0] shadow [16];
   check_t      check_q [$];
   int          n_checks;
   int          bp_max;

   ucore_top u_ucore_top (
      .clk, .rst,
      .awvalid, .awready, .aw,
      .wvalid, .wready, .w,
      .bvalid, .bready,
      .arvalid, .arready, .ar,
      .rvalid, .rready, .r
   );

   always #CLK_HALF clk = ~clk;

   // expected rd value from the instruction set rules.
   function automatic logic [31:0] expected_result(input instr_t ins, input logic [31:0] a,
                                                   input logic [31:0] b);
      logic [31:0] y;
      int          i;
      y = 32'd0;
      case (ins.opcode)
         OP_ADD:  y = a + b;
         OP_SUB:  y = a - b;
         OP_AND:  y = a & b;
         OP_OR:   y = a | b;
         OP_XOR:  y = a ^ b;
         OP_SHL:  y = a << b[4:0];
         OP_SHR:  y = a >> b[4:0];
         OP_LDI:  y = {16'd0, ins.imm};
         OP_MUL:  y = a * b;
         OP_POPC: begin
            for (i = 0; i < 32; i++) begin
               y = y + b[i];
            end
         end
         default: y = 32'd0;
      endcase
      return y;
   endfunction

   function automatic logic writes_reg(input opcode_t op);
      return op <= OP_POPC;
   endfunction

   function automatic logic is_ucode(input opcode_t op);
      return op == OP_MUL || op == OP_POPC;
   endfunction

   function automatic instr_t make_instr(input logic [3:0] op, input logic [3:0] rd,
                                         input logic [3:0] rs1, input logic [3:0] rs2,
                                         input logic [15:0] imm);
      instr_t ins;
      ins.opcode = opcode_t'(op);
      ins.rd     = rd;
      ins.rs1    = rs1;
      ins.rs2    = rs2;
      ins.imm    = imm;
      return ins;
   endfunction

   function automatic instr_t random_instr(input logic [3:0] op);
      return make_instr(op, 4'($urandom_range(15, 0)), 4'($urandom_range(15, 0)),
                        4'($urandom_range(15, 0)), 16'($urandom));
   endfunction

   function automatic string reg_name(input logic [7:0] addr);
      if (addr == ADDR_STATUS) begin
         return "status";
      end
      return $sformatf("r%0d", (addr - ADDR_REG_BASE) >> 2);
   endfunction

   task automatic random_stall();
      int n;
      n = (bp_max > 0) ? $urandom_range(bp_max, 0) : 0;
      if (n > 0) begin
         repeat (n) @(posedge clk);
         #2;
      end
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
      awvalid = 1'b1;
      aw.addr = addr;
      wvalid  = 1'b1;
      w.data  = data;
      do begin
         @(posedge clk);
      end while (!(awready && wready));
      #2;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      random_stall();
      bready = 1'b1;
      do begin
         @(posedge clk);
      end while (!bvalid);
      #2;
      bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
      arvalid = 1'b1;
      ar.addr = addr;
      do begin
         @(posedge clk);
      end while (!arready);
      #2;
      arvalid = 1'b0;
      random_stall();
      rready = 1'b1;
      do begin
         @(posedge clk);
      end while (!rvalid);
      data = r.data;
      // every response is OKAY.
      assert (r.resp === 2'b00) else begin
         $display("** Error: r.resp = 0x%01h, expected 0x0", r.resp);
         $display("TEST FAILED");
         $fatal(1, "read response is not OKAY");
      end
      #2;
      rready = 1'b0;
   endtask

   task automatic check_reg(input logic [3:0] idx);
      logic [7:0]  addr;
      logic [31:0] data;
      addr = ADDR_REG_BASE + {2'b00, idx, 2'b00};
      axil_read(addr, data);
      check_q.push_back(check_t'{addr, data, shadow[idx]});
   endtask

   task automatic check_all_regs();
      int i;
      for (i = 0; i < 16; i++) begin
         check_reg(4'(i));
      end
   endtask

   task automatic check_status(input logic [31:0] exp);
      logic [31:0] data;
      axil_read(ADDR_STATUS, data);
      check_q.push_back(check_t'{ADDR_STATUS, data, exp});
   endtask

   // shadow takes the result in issue order.
   task automatic issue(input instr_t ins);
      axil_write(ADDR_INSTR, ins);
      if (writes_reg(ins.opcode)) begin
         shadow[ins.rd] = expected_result(ins, shadow[ins.rs1], shadow[ins.rs2]);
      end
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      do begin
         axil_read(ADDR_STATUS, st);
      end while (st[STATUS_BUSY_BIT]);
   endtask

   task automatic run_ucode(input instr_t ins);
      issue(ins);
      wait_idle();
      check_all_regs();
   endtask

   always @(posedge clk) begin : compare_results
      check_t c;
      while (check_q.size() > 0) begin
         c = check_q.pop_front();
         n_checks++;
         assert (c.got === c.exp) else begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", reg_name(c.addr), c.got, c.exp);
            $display("TEST FAILED");
            $fatal(1, "read data does not match the reference model");
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the DUT stopped responding",
               WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

   initial begin : stimulus
      instr_t ins;
      int     i;
      int     k;
      clk      = 1'b0;
      rst      = 1'b1;
      awvalid  = 1'b0;
      aw       = '0;
      wvalid   = 1'b0;
      w        = '0;
      bready   = 1'b0;
      arvalid  = 1'b0;
      ar       = '0;
      rready   = 1'b0;
      n_checks = 0;
      bp_max   = 0;
      for (i = 0; i < 16; i++) begin
         shadow[i] = 32'd0;
      end
      void'($urandom(SEED));
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;

      check_all_regs();
      check_status(32'h0);

      // LDI first in each round so later ops see loaded values.
      for (i = 0; i < 5; i++) begin
         for (k = 0; k < 8; k++) begin
            ins = random_instr(4'((k + 7) % 8));
            issue(ins);
            check_reg(ins.rd);
         end
      end
      check_all_regs();

      // multiply and popcount, aliased and zero operands.
      issue(make_instr(OP_LDI, 4'd9, 4'd0, 4'd0, 16'h0));
      run_ucode(make_instr(OP_MUL, 4'd1, 4'd2, 4'd3, 16'h0));
      run_ucode(make_instr(OP_MUL, 4'd4, 4'd4, 4'd5, 16'h0));
      run_ucode(make_instr(OP_MUL, 4'd6, 4'd7, 4'd6, 16'h0));
      run_ucode(make_instr(OP_MUL, 4'd8, 4'd9, 4'd10, 16'h0));
      run_ucode(make_instr(OP_MUL, 4'd8, 4'd10, 4'd9, 16'h0));
      run_ucode(make_instr(OP_MUL, 4'd12, 4'd12, 4'd12, 16'h0));
      run_ucode(make_instr(OP_POPC, 4'd2, 4'd2, 4'd3, 16'h0));
      run_ucode(make_instr(OP_POPC, 4'd3, 4'd1, 4'd3, 16'h0));
      run_ucode(make_instr(OP_POPC, 4'd11, 4'd12, 4'd9, 16'h0));
      for (k = 0; k < 4; k++) begin
         run_ucode(random_instr(4'(OP_MUL + k % 2)));
      end

      // full 32 pass multiply, then an instruction queued behind it.
      issue(make_instr(OP_LDI, 4'd1, 4'd0, 4'd0, 16'h0));
      issue(make_instr(OP_LDI, 4'd2, 4'd0, 4'd0, 16'h1));
      issue(make_instr(OP_SUB, 4'd3, 4'd1, 4'd2, 16'h0));
      issue(make_instr(OP_LDI, 4'd5, 4'd0, 4'd0, 16'h1234));
      issue(make_instr(OP_MUL, 4'd4, 4'd5, 4'd3, 16'h0));
      check_status(32'h1);
      issue(make_instr(OP_XOR, 4'd6, 4'd4, 4'd5, 16'h0));
      wait_idle();
      check_all_regs();

      // illegal opcodes.
      for (k = 10; k < 16; k += 5) begin
         issue(random_instr(4'(k)));
         check_status(32'h2);
         check_status(32'h0);
         check_all_regs();
      end

      // random back-pressure on both response channels.
      bp_max = 6;
      for (k = 0; k < 24; k++) begin
         ins = random_instr(4'($urandom_range(9, 0)));
         issue(ins);
         if (is_ucode(ins.opcode)) begin
            wait_idle();
         end
         check_reg(ins.rd);
      end
      check_all_regs();
      bp_max = 0;

      repeat (2) @(posedge clk);
      if (check_q.size() == 0 && n_checks > 0) begin
         $display("%0d checks compared", n_checks);
         $display("TEST PASSED");
         $finish;
      end else begin
         $display("compare process left %0d checks unread", check_q.size());
         $display("TEST FAILED");
         $fatal(1, "comparison incomplete");
      end
   end

endmodule

`default_nettype wire

// File: ucore_top.f
source/core_pkg.sv
source/bus_pkg.sv
source/reg_file.sv
source/alu.sv
source/ucode_seq.sv
source/exec_ctrl.sv
source/axil_slave.sv
source/ucore_top.sv
tests/ucore_properties.sv
tests/ucore_tb.sv
